// ==== vlog.f ====
verilog/div_ctl_pkg.sv
verilog/div_ctl_if.sv
verilog/div_seq_fsm.sv
verilog/div_step_cnt.sv
verilog/div_qbit_pred.sv
verilog/div_ovfl_cc.sv
verilog/div_ctl_top.sv
tb/tb_clkgen.sv
tb/tb_div_ctl.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_div_ctl \
		-f vlog.f -o tb_div_ctl_sim
	./obj_dir/tb_div_ctl_sim

clean:
	rm -rf obj_dir

// ==== tb/tb_div_ctl.sv ====
// divider control testbench; random datapath bits every cycle, even-numbered runs get aborted
`timescale 1ns/1ps
`default_nettype none

module tb_div_ctl;

   logic clk;
   logic rst_n;
   logic input_vld, wb_ack, div_abort, signed_div, div64;
   logic dividend_msb, divisor_in_31, xin_msb_l, x_msb, d_msb, d_62, cout64;
   logic detect_zero_high, detect_zero_low;
   logic upper32_equal, gencc_in_msb_l, gencc_in_31, low32_nonzero;
   logic wb_req, ld_inputs, sel_adder, keep_d, keepx, last_cycle, almostlast_cycle;
   logic xinmask, dividend_sign, newq, subtract_l, cin;
   logic sel_64b, sel_u32, sel_pos32, sel_neg32, upper32_zero, upper33_zero, upper33_one;
   logic [div_ctl_pkg::div_cc_w-1:0] cc;

   // edges since the load edge, 0 while idle
   int pos;
   int cycle_cnt;
   int check_cnt;
   logic [31:0] lfsr_state;
   logic stat_phase;
   // values seen at the last rising edge
   logic prev_rst_n, prev_ld, prev_sign, prev_sub, prev_d_msb, prev_cout64, prev_signed;
   logic [3:0] prev_stat;
   logic neg_cap;

   tb_clkgen tb_clkgen_inst (.clk (clk), .rst_n (rst_n));

   div_ctl_top div_ctl_top_inst (.*);

   //////////////////////////////
   // random bits
   //////////////////////////////

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'hD000_0001 : 32'h0);
   endfunction

   // one lfsr step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return v;
   endfunction

   //////////////////////////////
   // expected values
   //////////////////////////////

   // {wb_req, last_cycle, almostlast_cycle, keepx, sel_adder, keep_d, ld_inputs}
   function automatic logic [6:0] strobe_ref(input int p, input logic vld);
      logic run;
      logic almost;
      logic adder;
      run = (p >= 1) && (p <= div_ctl_pkg::div_run_cycles);
      almost = (p == div_ctl_pkg::div_run_cycles) && !vld;
      adder = (run || p == div_ctl_pkg::div_run_cycles + 1) && !vld;
      return {p == div_ctl_pkg::div_run_cycles + 4, p == div_ctl_pkg::div_run_cycles + 1,
              almost, !(vld || almost), adder, !(adder || vld), vld};
   endfunction

   // newq one cycle after its inputs
   function automatic logic qbit_ref(input logic was_rst, input logic ld, input logic sign,
                                     input logic dmsb, input logic sub, input logic cout);
      if (!was_rst) begin
         return 1'b0;
      end
      if (ld) begin
         return sign;
      end
      return ~(dmsb ^ sub) ^ cout;
   endfunction

   // selects and cc from status seen one edge earlier, st = {eq32, msb_l, bit31, nz_low}
   function automatic logic [14:0] ovfl_ref(input logic sgn, input logic d64,
                                            input logic both_neg, input logic [3:0] st);
      logic neg, flip, s_u32, s_pos, s_neg, z32, z33, o33, uov, pov, nov, v;
      logic [3:0] xcc;
      logic [3:0] icc;
      neg = ~st[2];
      // two negative operands and a negative result, the sign wrapped
      flip = both_neg && neg;
      s_u32 = !d64 && !sgn;
      s_pos = !d64 && sgn && (!neg || flip);
      s_neg = !d64 && sgn && neg && !flip;
      // upper word must be a plain zero or one extension
      z32 = st[3] && !neg;
      z33 = z32 && !st[1];
      o33 = st[3] && neg && st[1];
      uov = s_u32 && !z32;
      pov = s_pos && !z33;
      nov = s_neg && !o33;
      v = uov || pov || nov;
      xcc = '0;
      icc = '0;
      xcc[div_ctl_pkg::cc_n] = neg && !uov && !pov;
      xcc[div_ctl_pkg::cc_z] = z32 && !st[0];
      icc[div_ctl_pkg::cc_n] = (st[1] && !pov) || nov || uov;
      icc[div_ctl_pkg::cc_z] = !st[0] && !v;
      icc[div_ctl_pkg::cc_v] = v;
      return {d64, s_u32, s_pos, s_neg, z32, z33, o33, xcc, icc};
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
      check_cnt++;
      if (exp_val !== act_val) begin
         $display("ERROR %s expected %0h actual %0h", name, exp_val, act_val);
         $display("TESTS FAILED");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   //////////////////////////////
   // reference state and timeout
   //////////////////////////////

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      prev_rst_n <= rst_n;
      prev_ld <= input_vld;
      prev_sign <= signed_div & dividend_msb;
      prev_sub <= ~subtract_l;
      prev_d_msb <= d_msb;
      prev_cout64 <= cout64;
      prev_signed <= signed_div;
      prev_stat <= {upper32_equal, gencc_in_msb_l, gencc_in_31, low32_nonzero};
      if (!rst_n) begin
         neg_cap <= 1'b0;
      end else if (input_vld) begin
         neg_cap <= dividend_msb & divisor_in_31;
      end
      // load, 64 run, last calc, two staging edges, then done until ack
      if (!rst_n || div_abort) begin
         pos <= 0;
      end else if (pos == 0) begin
         pos <= input_vld ? 1 : 0;
      end else if (pos < div_ctl_pkg::div_run_cycles + 4) begin
         pos <= pos + 1;
      end else if (wb_ack) begin
         pos <= 0;
      end
      // 20 operations of at most 80 cycles each
      if (cycle_cnt >= 20 * 80) begin
         $display("TESTS FAILED");
         $fatal(1, "timeout, the run went past its cycle limit");
      end
   end

   // outputs are settled at the falling edge
   always @(negedge clk) begin
      if (rst_n) begin
         check_val("strobes", 32'(strobe_ref(pos, input_vld)),
                   32'({wb_req, last_cycle, almostlast_cycle, keepx, sel_adder, keep_d,
                        ld_inputs}));
         // operand signs only count for signed division
         check_val("sign_masks", 32'({signed_div & divisor_in_31, signed_div & dividend_msb}),
                   32'({xinmask, dividend_sign}));
         check_val("newq", 32'(qbit_ref(prev_rst_n, prev_ld, prev_sign, prev_d_msb, prev_sub,
                                        prev_cout64)), 32'(newq));
         if (pos != div_ctl_pkg::div_run_cycles + 1) begin
            check_val("cin", 32'({~subtract_l}), 32'(cin));
         end else if (!prev_signed) begin
            check_val("cin_last_unsigned", 32'h0, 32'(cin));
         end
         check_val("ovfl_cc", 32'(ovfl_ref(signed_div, div64, neg_cap, prev_stat)),
                   32'({sel_64b, sel_u32, sel_pos32, sel_neg32, upper32_zero, upper33_zero,
                        upper33_one, cc}));
      end
   end

   //////////////////////////////
   // stimulus
   //////////////////////////////

   task automatic init_inputs();
      input_vld <= 1'b0;
      wb_ack <= 1'b0;
      div_abort <= 1'b0;
      signed_div <= 1'b0;
      div64 <= 1'b0;
      dividend_msb <= 1'b0;
      divisor_in_31 <= 1'b0;
      xin_msb_l <= 1'b0;
      x_msb <= 1'b0;
      d_msb <= 1'b0;
      d_62 <= 1'b0;
      cout64 <= 1'b0;
      detect_zero_high <= 1'b0;
      detect_zero_low <= 1'b0;
      upper32_equal <= 1'b0;
      gencc_in_msb_l <= 1'b0;
      gencc_in_31 <= 1'b0;
      low32_nonzero <= 1'b0;
   endtask

   // one clock with fresh datapath bits, status changes every second cycle
   task automatic next_cycle(input logic vld, input logic abort, input logic ack);
      logic [31:0] r;
      logic [31:0] s;
      @(posedge clk);
      r = take_bits(7);
      input_vld <= vld;
      div_abort <= abort;
      wb_ack <= ack;
      xin_msb_l <= r[0];
      x_msb <= r[1];
      d_msb <= r[2];
      d_62 <= r[3];
      cout64 <= r[4];
      detect_zero_high <= r[5];
      detect_zero_low <= r[6];
      stat_phase = ~stat_phase;
      if (stat_phase) begin
         s = take_bits(4);
         upper32_equal <= s[0];
         gencc_in_msb_l <= s[1];
         gencc_in_31 <= s[2];
         low32_nonzero <= s[3];
      end
   endtask

   // load pulse with new operand signs and mode
   task automatic start_div();
      logic [31:0] r;
      next_cycle(1'b1, 1'b0, 1'b0);
      r = take_bits(4);
      signed_div <= r[0];
      div64 <= r[1];
      dividend_msb <= r[2];
      divisor_in_31 <= r[3];
   endtask

   task automatic wait_wb_req();
      @(negedge clk);
      while (!wb_req) begin
         next_cycle(1'b0, 1'b0, 1'b0);
         @(negedge clk);
      end
   endtask

   initial begin
      int k;
      lfsr_state = 32'h7235;
      stat_phase = 1'b0;
      init_inputs();
      @(negedge clk);
      while (!rst_n) begin
         @(negedge clk);
      end
      for (int op = 0; op < 20; op++) begin
         start_div();
         if ((op % 2) == 0) begin
            // kill somewhere inside run
            k = int'(take_bits(6)) % 62 + 1;
            repeat (k) next_cycle(1'b0, 1'b0, 1'b0);
            next_cycle(1'b0, 1'b1, 1'b0);
            next_cycle(1'b0, 1'b0, 1'b0);
         end else begin
            // full division, ack held off for 0 to 7 cycles
            wait_wb_req();
            k = int'(take_bits(3));
            repeat (k) next_cycle(1'b0, 1'b0, 1'b0);
            next_cycle(1'b0, 1'b0, 1'b1);
            next_cycle(1'b0, 1'b0, 1'b0);
         end
      end
      repeat (4) next_cycle(1'b0, 1'b0, 1'b0);
      if (check_cnt > 0) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         $display("TESTS FAILED");
         $fatal(1, "no check was run");
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
// testbench clock and reset; 40 ns period, rst_n low for the first 3 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic clk,
   output logic rst_n
);

   // rising edges seen so far, saturates at 3
   int rst_cnt;

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // counts the reset edges, then stays put
   always @(posedge clk) begin
      if (rst_cnt < 3) begin
         rst_cnt <= rst_cnt + 1;
      end
   end

   assign rst_n = (rst_cnt >= 3);

endmodule

`default_nettype wire

// ==== verilog/div_ctl_top.sv ====
// divider control top; datapath lives outside, all status inputs come from it
`timescale 1ns/1ps
`default_nettype none

module div_ctl_top (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             input_vld,
   input  logic                             wb_ack,
   input  logic                             div_abort,
   input  logic                             signed_div,
   input  logic                             div64,
   input  logic                             dividend_msb,
   input  logic                             divisor_in_31,
   input  logic                             xin_msb_l,
   input  logic                             x_msb,
   input  logic                             d_msb,
   input  logic                             d_62,
   input  logic                             cout64,
   input  logic                             detect_zero_high,
   input  logic                             detect_zero_low,
   input  logic                             upper32_equal,
   input  logic                             gencc_in_msb_l,
   input  logic                             gencc_in_31,
   input  logic                             low32_nonzero,
   output logic                             wb_req,
   output logic                             ld_inputs,
   output logic                             sel_adder,
   output logic                             keep_d,
   output logic                             keepx,
   output logic                             last_cycle,
   output logic                             almostlast_cycle,
   output logic                             xinmask,
   output logic                             dividend_sign,
   output logic                             newq,
   output logic                             subtract_l,
   output logic                             cin,
   output logic                             sel_64b,
   output logic                             sel_u32,
   output logic                             sel_pos32,
   output logic                             sel_neg32,
   output logic                             upper32_zero,
   output logic                             upper33_zero,
   output logic                             upper33_one,
   output logic [div_ctl_pkg::div_cc_w-1:0] cc
);

   logic cnt_last;

   div_step_if   step_bus ();
   div_status_if stat_bus ();

   // datapath status onto the bundle
   assign stat_bus.upper32_equal = upper32_equal;
   assign stat_bus.gencc_in_msb_l = gencc_in_msb_l;
   assign stat_bus.gencc_in_31 = gencc_in_31;
   assign stat_bus.low32_nonzero = low32_nonzero;

   // strobes back out to the datapath
   assign ld_inputs = step_bus.ld_inputs;
   assign keepx = step_bus.keepx;
   assign last_cycle = step_bus.last_cycle;
   assign almostlast_cycle = step_bus.almostlast_cycle;

   div_seq_fsm div_seq_fsm_inst (
      .clk (clk), .rst_n (rst_n), .input_vld (input_vld), .wb_ack (wb_ack),
      .div_abort (div_abort), .cnt_last (cnt_last), .wb_req (wb_req),
      .sel_adder (sel_adder), .keep_d (keep_d), .step (step_bus)
   );

   div_step_cnt div_step_cnt_inst (
      .clk (clk), .rst_n (rst_n), .run (step_bus.run), .cnt_last (cnt_last)
   );

   div_qbit_pred div_qbit_pred_inst (
      .clk (clk), .rst_n (rst_n), .signed_div (signed_div),
      .dividend_msb (dividend_msb), .divisor_in_31 (divisor_in_31),
      .xin_msb_l (xin_msb_l), .x_msb (x_msb), .d_msb (d_msb), .d_62 (d_62),
      .cout64 (cout64), .detect_zero_high (detect_zero_high),
      .detect_zero_low (detect_zero_low), .xinmask (xinmask),
      .dividend_sign (dividend_sign), .newq (newq), .subtract_l (subtract_l),
      .cin (cin), .step (step_bus)
   );

   div_ovfl_cc div_ovfl_cc_inst (
      .clk (clk), .rst_n (rst_n), .signed_div (signed_div), .div64 (div64),
      .dividend_msb (dividend_msb), .divisor_in_31 (divisor_in_31),
      .sel_64b (sel_64b), .sel_u32 (sel_u32), .sel_pos32 (sel_pos32),
      .sel_neg32 (sel_neg32), .upper32_zero (upper32_zero),
      .upper33_zero (upper33_zero), .upper33_one (upper33_one), .cc (cc),
      .stat (stat_bus), .step (step_bus)
   );

endmodule

`default_nettype wire

// ==== verilog/div_ovfl_cc.sv ====
// overflow selects and condition codes; status is staged one cycle, icc carry is always 0
`timescale 1ns/1ps
`default_nettype none

module div_ovfl_cc (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              signed_div,
   input  logic                              div64,
   input  logic                              dividend_msb,
   input  logic                              divisor_in_31,
   output logic                              sel_64b,
   output logic                              sel_u32,
   output logic                              sel_pos32,
   output logic                              sel_neg32,
   output logic                              upper32_zero,
   output logic                              upper33_zero,
   output logic                              upper33_one,
   output logic [div_ctl_pkg::div_cc_w-1:0]  cc,
   div_status_if.cc                          stat,
   div_step_if.data                          step
);

   logic upper32_equal_d1;
   logic gencc_in_msb_l_d1;
   logic gencc_in_31_d1;
   logic low32_nonzero_d1;
   logic inputs_neg_q;
   logic large_neg_ovfl;
   logic unsign_ovfl;
   logic pos_ovfl;
   logic neg_ovfl;
   logic div_v;
   logic [div_ctl_pkg::div_cc_w/2-1:0] xcc;
   logic [div_ctl_pkg::div_cc_w/2-1:0] icc;

   // status staging, one cycle
   always_ff @(posedge clk) begin
      upper32_equal_d1 <= stat.upper32_equal;
      gencc_in_msb_l_d1 <= stat.gencc_in_msb_l;
      gencc_in_31_d1 <= stat.gencc_in_31;
      low32_nonzero_d1 <= stat.low32_nonzero;
   end

   // most negative / -1 in 32 bit mode flips the sign, caught here
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         inputs_neg_q <= 1'b0;
      end else if (step.ld_inputs) begin
         inputs_neg_q <= dividend_msb & divisor_in_31;
      end
   end
   assign large_neg_ovfl = inputs_neg_q & ~gencc_in_msb_l_d1;

   //////////////////////////////
   // overflow selects
   //////////////////////////////

   assign sel_64b = div64;
   assign sel_u32 = ~div64 & ~signed_div;
   assign sel_pos32 = ~div64 & signed_div & (gencc_in_msb_l_d1 | large_neg_ovfl);
   assign sel_neg32 = ~div64 & signed_div & ~gencc_in_msb_l_d1 & ~large_neg_ovfl;

   // extension checks on the upper word
   assign upper32_zero = upper32_equal_d1 & gencc_in_msb_l_d1;
   assign upper33_zero = upper32_equal_d1 & gencc_in_msb_l_d1 & ~gencc_in_31_d1;
   assign upper33_one = upper32_equal_d1 & ~gencc_in_msb_l_d1 & gencc_in_31_d1;

   assign unsign_ovfl = sel_u32 & ~upper32_zero;
   assign pos_ovfl = sel_pos32 & ~upper33_zero;
   assign neg_ovfl = sel_neg32 & ~upper33_one;
   assign div_v = unsign_ovfl | pos_ovfl | neg_ovfl;

   //////////////////////////////
   // condition codes
   //////////////////////////////

   always_comb begin
      xcc = '0;
      icc = '0;
      xcc[div_ctl_pkg::cc_n] = ~gencc_in_msb_l_d1 & ~unsign_ovfl & ~pos_ovfl;
      xcc[div_ctl_pkg::cc_z] = upper32_equal_d1 & gencc_in_msb_l_d1 & ~low32_nonzero_d1;
      icc[div_ctl_pkg::cc_n] = (gencc_in_31_d1 & ~pos_ovfl) | neg_ovfl | unsign_ovfl;
      // low word zero only counts without overflow
      icc[div_ctl_pkg::cc_z] = ~low32_nonzero_d1 & ~div_v;
      icc[div_ctl_pkg::cc_v] = div_v;
   end

   assign cc = {xcc, icc};

endmodule

`default_nettype wire

// ==== verilog/div_qbit_pred.sv ====
// quotient bit prediction and carry-in; flops update every edge, one cycle of latency
`timescale 1ns/1ps
`default_nettype none

module div_qbit_pred (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     signed_div,
   input  logic     dividend_msb,
   input  logic     divisor_in_31,
   input  logic     xin_msb_l,
   input  logic     x_msb,
   input  logic     d_msb,
   input  logic     d_62,
   input  logic     cout64,
   input  logic     detect_zero_high,
   input  logic     detect_zero_low,
   output logic     xinmask,
   output logic     dividend_sign,
   output logic     newq,
   output logic     subtract_l,
   output logic     cin,
   div_step_if.data step
);

   logic subtract;
   logic divisor_sign;
   logic q_pred;
   logic firstlast_sub;
   logic detect_zero;
   logic zero_rem_d;
   logic zero_rem_q;
   logic last_cin_d;
   logic last_cin_q;

   //////////////////////////////
   // sign extension masks
   //////////////////////////////

   assign dividend_sign = signed_div & dividend_msb;
   assign xinmask = signed_div & divisor_in_31;
   assign divisor_sign = signed_div & x_msb;

   // bit 64 of the adder against the divisor sign collapses to this,
   // cout64 then flips it late to keep the carry off the long path
   assign q_pred = ~(d_msb ^ subtract) ^ cout64;

   // first and last cycle subtract, none on the almost-last cycle
   assign firstlast_sub = ~step.almostlast_cycle &
                          (~signed_div | (dividend_msb == ~xin_msb_l));

   //////////////////////////////
   // zero remainder and carry-in
   //////////////////////////////

   assign detect_zero = detect_zero_low & detect_zero_high;
   // remembers a zero partial remainder, cleared by a load or a set d_62
   assign zero_rem_d = ~step.ld_inputs & (~d_62 | step.almostlast_cycle) &
                       (detect_zero | zero_rem_q);
   // quotient correction for signed division only
   assign last_cin_d = signed_div & ((divisor_sign & ~d_62) |
                                     (~divisor_sign & d_62 & ~zero_rem_d) |
                                     (divisor_sign & d_62 & zero_rem_d));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         newq <= 1'b0;
         subtract <= 1'b0;
         zero_rem_q <= 1'b0;
         last_cin_q <= 1'b0;
      end else begin
         newq <= step.ld_inputs ? dividend_sign : q_pred;
         subtract <= step.keepx ? q_pred : firstlast_sub;
         zero_rem_q <= zero_rem_d;
         last_cin_q <= last_cin_d;
      end
   end

   assign subtract_l = ~subtract;
   assign cin = step.last_cycle ? last_cin_q : subtract;

endmodule

`default_nettype wire

// ==== verilog/div_step_cnt.sv ====
// run-cycle counter; wraps silently if run is held past the terminal count
`timescale 1ns/1ps
`default_nettype none

module div_step_cnt (
   input  logic clk,
   input  logic rst_n,
   input  logic run,
   output logic cnt_last
);

   logic [div_ctl_pkg::div_cnt_w-1:0] cnt;

   // cleared outside run, so the first run cycle sees zero
   always_ff @(posedge clk) begin
      if (!rst_n || !run) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // all ones marks the last of the run cycles
   assign cnt_last = &cnt;

endmodule

`default_nettype wire

// ==== verilog/div_seq_fsm.sv ====
// division sequencer; input_vld is only taken in idle, abort wins over every transition
`timescale 1ns/1ps
`default_nettype none

module div_seq_fsm (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     input_vld,
   input  logic     wb_ack,
   input  logic     div_abort,
   input  logic     cnt_last,
   output logic     wb_req,
   output logic     sel_adder,
   output logic     keep_d,
   div_step_if.fsm  step
);

   div_ctl_pkg::div_state_e state;
   div_ctl_pkg::div_state_e state_nxt;

   //////////////////////////////
   // state register
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= div_ctl_pkg::st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // load, 64 run, last calc, two overflow staging cycles, then hold in done
   always_comb begin
      state_nxt = state;
      case (state)
         div_ctl_pkg::st_idle:      if (input_vld) state_nxt = div_ctl_pkg::st_run;
         div_ctl_pkg::st_run:       if (cnt_last) state_nxt = div_ctl_pkg::st_last_calc;
         div_ctl_pkg::st_last_calc: state_nxt = div_ctl_pkg::st_chk_ovfl;
         // chk and fix only give the staged overflow checks time to settle
         div_ctl_pkg::st_chk_ovfl:  state_nxt = div_ctl_pkg::st_fix_ovfl;
         div_ctl_pkg::st_fix_ovfl:  state_nxt = div_ctl_pkg::st_done;
         div_ctl_pkg::st_done:      if (wb_ack) state_nxt = div_ctl_pkg::st_idle;
         default:                   state_nxt = div_ctl_pkg::st_idle;
      endcase
      // kill from the pipe, back to idle at the next edge
      if (div_abort) begin
         state_nxt = div_ctl_pkg::st_idle;
      end
   end

   //////////////////////////////
   // strobes
   //////////////////////////////

   // load pulse passes straight through
   assign step.ld_inputs = input_vld;
   assign step.run = (state == div_ctl_pkg::st_run);

   // terminal count in run, masked by a new load
   assign step.almostlast_cycle = step.run & cnt_last & ~input_vld;
   assign step.last_cycle = (state == div_ctl_pkg::st_last_calc);

   // adder result feeds the d register in run and last calc
   assign sel_adder = (step.run | step.last_cycle) & ~input_vld;
   assign keep_d = ~(sel_adder | input_vld);
   assign step.keepx = ~(input_vld | step.almostlast_cycle);

   // level request, held until the ack edge
   assign wb_req = (state == div_ctl_pkg::st_done);

endmodule

`default_nettype wire

// ==== verilog/div_ctl_if.sv ====
// sequence strobe and result status bundles; no clock inside, purely combinational nets
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////
// sequence strobes
//////////////////////////////

// driven by the sequencer, read by the datapath control blocks
interface div_step_if;
   // load cycle, first cycle of a division
   logic ld_inputs;
   // terminal run cycle, one before last_cycle
   logic almostlast_cycle;
   // final calculation cycle
   logic last_cycle;
   // low while the subtract flop takes the first/last term
   logic keepx;
   // high through the 64 run cycles
   logic run;

   modport fsm (
      output ld_inputs, almostlast_cycle, last_cycle, keepx, run
   );

   modport data (
      input ld_inputs, almostlast_cycle, last_cycle, keepx, run
   );
endinterface

//////////////////////////////
// result status
//////////////////////////////

// raw checks on the datapath result, staged inside the cc block
interface div_status_if;
   logic upper32_equal;
   // inverted msb of the result
   logic gencc_in_msb_l;
   logic gencc_in_31;
   logic low32_nonzero;

   modport cc (
      input upper32_equal, gencc_in_msb_l, gencc_in_31, low32_nonzero
   );
endinterface

`default_nettype wire

// ==== verilog/div_ctl_pkg.sv ====
// divider control constants; fixed 64 run cycles, one-hot states, no MULS support
`default_nettype none

package div_ctl_pkg;

   //////////////////////////////
   // sequence sizing
   //////////////////////////////

   // step counter width, run length is two to this power
   localparam int div_cnt_w = 6;
   localparam int div_run_cycles = 2 ** div_cnt_w;

   //////////////////////////////
   // condition codes
   //////////////////////////////

   // xcc sits in the upper nibble, icc in the lower one
   localparam int div_cc_w = 8;

   // bit positions inside one four-bit code
   localparam int cc_n = 3;
   localparam int cc_z = 2;
   localparam int cc_v = 1;
   localparam int cc_c = 0;

   // one-hot sequence states
   typedef enum logic [5:0] {
      st_idle      = 6'b000001,
      st_run       = 6'b000010,
      st_last_calc = 6'b000100,
      st_chk_ovfl  = 6'b001000,
      st_fix_ovfl  = 6'b010000,
      st_done      = 6'b100000
   } div_state_e;

endpackage

`default_nettype wire
